/* design/seq_pkg.sv */
package seq_pkg;

        // Data-processing view of an instruction word.
        typedef struct packed {
                logic [3:0]  cond;
                logic [1:0]  kind;
                logic        imm;
                logic [3:0]  opcode;
                logic        s;
                logic [3:0]  rn;
                logic [3:0]  rd;
                logic [11:0] operand;
        } dp_fields_t;

        // Single word load/store view that also spots a swap.
        typedef struct packed {
                logic [3:0]  cond;
                logic [1:0]  kind;
                logic        i;
                logic        p;
                logic        u;
                logic        b;
                logic        w;
                logic        l;
                logic [3:0]  rn;
                logic [3:0]  rd;
                logic [11:0] offset;
        } st_fields_t;

        // Load/store multiple view.
        typedef struct packed {
                logic [3:0]  cond;
                logic [2:0]  kind;
                logic        p;
                logic        u;
                logic        s;
                logic        w;
                logic        l;
                logic [3:0]  rn;
                logic [15:0] reglist;
        } bt_fields_t;

        typedef union packed {
                dp_fields_t dp;
                st_fields_t st;
                bt_fields_t bt;
        } instr_t;

        localparam logic [3:0] OPC_MOV = 4'b1101;
        localparam logic [3:0] OPC_SUB = 4'b0010;

        // Class codes in bits 27:25 and 27:26.
        localparam logic [2:0] KIND_BLOCK  = 3'b100;
        localparam logic [1:0] KIND_SINGLE = 2'b01;

        // Bits 11:4 of a swap.
        localparam logic [7:0] SWP_SIG = 8'b0000_1001;

        localparam int unsigned REG_PC = 15;

        // Hidden registers are named together with a set extension bit.
        localparam logic [3:0] HID_D0 = 4'd0;
        localparam logic [3:0] HID_D1 = 4'd1;

        localparam logic [2:0] ST_IDLE     = 3'd0;
        localparam logic [2:0] ST_MEMOP    = 3'd1;
        localparam logic [2:0] ST_BASE_FIX = 3'd2;
        localparam logic [2:0] ST_WRITE_PC = 3'd3;
        localparam logic [2:0] ST_SWAP1    = 3'd4;
        localparam logic [2:0] ST_SWAP2    = 3'd5;

        localparam int unsigned XFER_STEP = 4;

        function automatic logic is_block_xfer(instr_t instr);
                return instr.bt.kind == KIND_BLOCK;
        endfunction

        // A swap has 00010 in bits 27:23, 00 in bits 21:20 and 00001001 in bits 11:4.
        function automatic logic is_swap(instr_t instr);
                return instr.st.kind == 2'b00 && !instr.st.i && instr.st.p &&
                       !instr.st.u && !instr.st.w && !instr.st.l &&
                       instr.st.offset[11:4] == SWP_SIG;
        endfunction

endpackage

/* design/reglist_walker.sv */
`timescale 1ns/1ps

module reglist_walker
(
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic                  i_clear,
        input  logic                  i_hold,
        input  logic                  i_load_list,
        input  logic                  i_advance,
        input  seq_pkg::instr_t       i_instruction,
        output logic [3:0]            o_index,
        output logic                  o_last
);

        logic [15:0] list_q;

        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_clear)
                begin
                        list_q <= 16'd0;
                end
                else if (!i_hold)
                begin
                        if (i_load_list)
                        begin
                                list_q <= i_instruction.bt.reglist;
                        end
                        else if (i_advance)
                        begin
                                // Drop the lowest set bit.
                                list_q <= list_q & (list_q - 16'd1);
                        end
                end
        end

        // Lowest set bit wins.
        always_comb
        begin
                o_index = 4'd0;
                for (int i = 15; i >= 0; i--)
                begin
                        if (list_q[i])
                        begin
                                o_index = 4'(i);
                        end
                end
        end

        assign o_last = (list_q != 16'd0) && ((list_q & (list_q - 16'd1)) == 16'd0);

endmodule

/* design/seq_fsm.sv */
`timescale 1ns/1ps

module seq_fsm
(
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic                  i_clear,
        input  logic                  i_hold,
        input  seq_pkg::instr_t       i_instruction,
        input  logic                  i_instruction_valid,
        input  logic                  i_last,
        output logic [2:0]            o_state,
        output logic                  o_load_list,
        output logic                  o_advance,
        output logic                  o_stall
);

        logic [2:0] state_q;
        logic [2:0] state_nxt;
        logic       load_with_pc;

        assign load_with_pc = i_instruction.bt.l &&
                              i_instruction.bt.reglist[seq_pkg::REG_PC];

        always_comb
        begin
                state_nxt   = state_q;
                o_load_list = 1'b0;
                o_advance   = 1'b0;
                o_stall     = 1'b0;

                case (state_q)
                seq_pkg::ST_IDLE:
                begin
                        if (i_instruction_valid && seq_pkg::is_block_xfer(i_instruction))
                        begin
                                o_load_list = 1'b1;
                                o_stall     = 1'b1;
                                // An empty list has nothing to transfer.
                                if (i_instruction.bt.reglist == 16'd0)
                                begin
                                        state_nxt = seq_pkg::ST_BASE_FIX;
                                end
                                else
                                begin
                                        state_nxt = seq_pkg::ST_MEMOP;
                                end
                        end
                        else if (i_instruction_valid && seq_pkg::is_swap(i_instruction))
                        begin
                                o_stall   = 1'b1;
                                state_nxt = seq_pkg::ST_SWAP1;
                        end
                end
                seq_pkg::ST_MEMOP:
                begin
                        o_advance = 1'b1;
                        o_stall   = 1'b1;
                        if (i_last)
                        begin
                                state_nxt = seq_pkg::ST_BASE_FIX;
                        end
                end
                seq_pkg::ST_BASE_FIX:
                begin
                        if (load_with_pc)
                        begin
                                o_stall   = 1'b1;
                                state_nxt = seq_pkg::ST_WRITE_PC;
                        end
                        else
                        begin
                                state_nxt = seq_pkg::ST_IDLE;
                        end
                end
                seq_pkg::ST_SWAP1:
                begin
                        o_stall   = 1'b1;
                        state_nxt = seq_pkg::ST_SWAP2;
                end
                default:
                begin
                        // Write-PC and swap2 both end the sequence.
                        state_nxt = seq_pkg::ST_IDLE;
                end
                endcase
        end

        // Clear beats hold.
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_clear)
                begin
                        state_q <= seq_pkg::ST_IDLE;
                end
                else if (!i_hold)
                begin
                        state_q <= state_nxt;
                end
        end

        assign o_state = state_q;

endmodule

/* design/uop_builder.sv */
`timescale 1ns/1ps

module uop_builder
(
        input  logic [2:0]            i_state,
        input  seq_pkg::instr_t       i_instruction,
        input  logic                  i_instruction_valid,
        input  logic [3:0]            i_index,
        output seq_pkg::instr_t       o_uop,
        output logic                  o_uop_valid,
        output logic                  o_rd_ext,
        output logic                  o_rn_ext,
        output logic                  o_rm_ext
);

        logic [3:0] cond;
        logic [3:0] rn;
        logic       up;
        logic [4:0] count;
        logic [7:0] size;
        logic       load_pc_slot;

        assign cond = i_instruction.bt.cond;
        assign rn   = i_instruction.bt.rn;
        assign up   = i_instruction.bt.u;

        // Bytes covered by the register list.
        always_comb
        begin
                count = 5'd0;
                for (int i = 0; i < 16; i++)
                begin
                        count = count + 5'(i_instruction.bt.reglist[i]);
                end
        end

        assign size = 8'(count * seq_pkg::XFER_STEP);

        assign load_pc_slot = i_instruction.bt.l && (i_index == 4'(seq_pkg::REG_PC));

        function automatic seq_pkg::instr_t dp_word(logic [3:0] c, logic imm,
                                                    logic [3:0] opc, logic s,
                                                    logic [3:0] src, logic [3:0] dst,
                                                    logic [11:0] operand);
                seq_pkg::instr_t w;
                w            = '0;
                w.dp.cond    = c;
                w.dp.imm     = imm;
                w.dp.opcode  = opc;
                w.dp.s       = s;
                w.dp.rn      = src;
                w.dp.rd      = dst;
                w.dp.operand = operand;
                return w;
        endfunction

        // Word or byte transfer with an immediate offset.
        function automatic seq_pkg::instr_t st_word(logic [3:0] c, logic p, logic b,
                                                    logic wb, logic l, logic [3:0] base,
                                                    logic [3:0] data, logic [11:0] offset);
                seq_pkg::instr_t w;
                w           = '0;
                w.st.cond   = c;
                w.st.kind   = seq_pkg::KIND_SINGLE;
                w.st.p      = p;
                w.st.u      = 1'b1;
                w.st.b      = b;
                w.st.w      = wb;
                w.st.l      = l;
                w.st.rn     = base;
                w.st.rd     = data;
                w.st.offset = offset;
                return w;
        endfunction

        always_comb
        begin
                o_uop       = i_instruction;
                o_uop_valid = i_instruction_valid;
                o_rd_ext    = 1'b0;
                o_rn_ext    = 1'b0;
                o_rm_ext    = 1'b0;

                case (i_state)
                seq_pkg::ST_IDLE:
                begin
                        if (i_instruction_valid && seq_pkg::is_block_xfer(i_instruction))
                        begin
                                o_rd_ext = 1'b1;
                                if (up)
                                begin
                                        o_uop = dp_word(cond, 1'b0, seq_pkg::OPC_MOV, 1'b0,
                                                        4'd0, seq_pkg::HID_D0, {8'd0, rn});
                                end
                                else
                                begin
                                        o_uop = dp_word(cond, 1'b1, seq_pkg::OPC_SUB, 1'b0,
                                                        rn, seq_pkg::HID_D0, {4'd0, size});
                                end
                        end
                        else if (i_instruction_valid && seq_pkg::is_swap(i_instruction))
                        begin
                                o_rd_ext = 1'b1;
                                o_uop    = st_word(cond, 1'b1, i_instruction.st.b, 1'b0, 1'b1,
                                                   i_instruction.st.rn, seq_pkg::HID_D0, 12'd0);
                        end
                end
                seq_pkg::ST_MEMOP:
                begin
                        // Descending lists run as ascending with P flipped.
                        o_uop_valid = 1'b1;
                        o_rn_ext    = 1'b1;
                        o_rd_ext    = load_pc_slot;
                        o_uop       = st_word(cond, up ~^ i_instruction.bt.p, 1'b0,
                                              up ~^ i_instruction.bt.p, i_instruction.bt.l,
                                              seq_pkg::HID_D0,
                                              load_pc_slot ? seq_pkg::HID_D1 : i_index,
                                              12'(seq_pkg::XFER_STEP));
                end
                seq_pkg::ST_BASE_FIX:
                begin
                        o_uop_valid = 1'b1;
                        if (!i_instruction.bt.w)
                        begin
                                o_uop = '0;
                        end
                        else if (up)
                        begin
                                o_rm_ext = 1'b1;
                                o_uop    = dp_word(cond, 1'b0, seq_pkg::OPC_MOV, 1'b0, 4'd0, rn,
                                                   {8'd0, seq_pkg::HID_D0});
                        end
                        else
                        begin
                                o_uop = dp_word(cond, 1'b1, seq_pkg::OPC_SUB, 1'b0, rn, rn,
                                                {4'd0, size});
                        end
                end
                seq_pkg::ST_WRITE_PC:
                begin
                        o_uop_valid = 1'b1;
                        o_rm_ext    = 1'b1;
                        o_uop       = dp_word(cond, 1'b0, seq_pkg::OPC_MOV, i_instruction.bt.s,
                                              4'd0, 4'(seq_pkg::REG_PC), {8'd0, seq_pkg::HID_D1});
                end
                seq_pkg::ST_SWAP1:
                begin
                        o_uop_valid = 1'b1;
                        o_uop       = st_word(cond, 1'b1, i_instruction.st.b, 1'b0, 1'b0,
                                              i_instruction.st.rn, i_instruction.st.offset[3:0],
                                              12'd0);
                end
                seq_pkg::ST_SWAP2:
                begin
                        o_uop_valid = 1'b1;
                        o_rm_ext    = 1'b1;
                        o_uop       = dp_word(cond, 1'b0, seq_pkg::OPC_MOV, 1'b0, 4'd0,
                                              i_instruction.st.rd, {8'd0, seq_pkg::HID_D0});
                end
                default:
                begin
                        o_uop = i_instruction;
                end
                endcase
        end

endmodule

/* design/block_xfer_sequencer.sv */
`timescale 1ns/1ps

module block_xfer_sequencer
(
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  seq_pkg::instr_t       i_instruction,
        input  logic                  i_instruction_valid,
        input  logic                  i_hold,
        input  logic                  i_clear,
        output seq_pkg::instr_t       o_uop,
        output logic                  o_uop_valid,
        output logic                  o_rd_ext,
        output logic                  o_rn_ext,
        output logic                  o_rm_ext,
        output logic                  o_stall
);

        logic [2:0] state;
        logic       load_list;
        logic       advance;
        logic [3:0] index;
        logic       last;

        seq_fsm u_seq_fsm
        (
                .i_clk                  (i_clk),
                .i_reset                (i_reset),
                .i_clear                (i_clear),
                .i_hold                 (i_hold),
                .i_instruction          (i_instruction),
                .i_instruction_valid    (i_instruction_valid),
                .i_last                 (last),
                .o_state                (state),
                .o_load_list            (load_list),
                .o_advance              (advance),
                .o_stall                (o_stall)
        );

        reglist_walker u_reglist_walker
        (
                .i_clk                  (i_clk),
                .i_reset                (i_reset),
                .i_clear                (i_clear),
                .i_hold                 (i_hold),
                .i_load_list            (load_list),
                .i_advance              (advance),
                .i_instruction          (i_instruction),
                .o_index                (index),
                .o_last                 (last)
        );

        uop_builder u_uop_builder
        (
                .i_state                (state),
                .i_instruction          (i_instruction),
                .i_instruction_valid    (i_instruction_valid),
                .i_index                (index),
                .o_uop                  (o_uop),
                .o_uop_valid            (o_uop_valid),
                .o_rd_ext               (o_rd_ext),
                .o_rn_ext               (o_rn_ext),
                .o_rm_ext               (o_rm_ext)
        );

endmodule

/* verification/seq_assertions.sv */
`timescale 1ns/1ps

module seq_assertions
(
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic                  i_hold,
        input  logic                  i_clear,
        input  logic                  i_stall,
        input  logic                  i_uop_valid
);

        // Unheld cycles so far in the current stall run.
        logic [5:0] stall_run;

        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_clear || !i_stall)
                begin
                        stall_run <= 6'd0;
                end
                else if (!i_hold)
                begin
                        stall_run <= stall_run + 6'd1;
                end
        end

        idle_after_reset: assert property (@(posedge i_clk) $fell(i_reset) |-> !i_stall)
                else $error("o_stall high in the first cycle after reset");

        valid_while_stalled: assert property (@(posedge i_clk) disable iff (i_reset)
                i_stall |-> i_uop_valid)
                else $error("o_stall high without a valid micro-op");

        // Full LDM with PC stalls for 18 cycles.
        bounded_stall: assert property (@(posedge i_clk) disable iff (i_reset)
                (i_stall && !i_hold) |-> stall_run < 6'd18)
                else $error("o_stall high for more than 18 unheld cycles");

endmodule

bind block_xfer_sequencer seq_assertions u_seq_assertions
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_hold                 (i_hold),
        .i_clear                (i_clear),
        .i_stall                (o_stall),
        .i_uop_valid            (o_uop_valid)
);

/* verification/tb_block_xfer_sequencer.sv */
`timescale 1ns/1ps

module tb_block_xfer_sequencer;

        localparam int NUM_ROWS = 10;

        logic            i_clk = 1'b0;
        logic            i_reset;
        seq_pkg::instr_t i_instruction;
        logic            i_instruction_valid;
        logic            i_hold;
        logic            i_clear;
        seq_pkg::instr_t o_uop;
        logic            o_uop_valid;
        logic            o_rd_ext;
        logic            o_rn_ext;
        logic            o_rm_ext;
        logic            o_stall;

        // One hold bit per micro-op; a clear step of -1 means no clear.
        seq_pkg::instr_t row_instr [NUM_ROWS];
        logic [7:0]      row_hold [NUM_ROWS];
        int              row_clear_at [NUM_ROWS];
        int              row_count [NUM_ROWS];

        // Expected micro-ops and {rd, rn, rm} extension bits of the current row.
        seq_pkg::instr_t exp_uop [$];
        logic [2:0]      exp_ext [$];

        integer seed = 32'h447f_53fe;
        int     cycle_count = 0;
        int     cycle_limit = 1000;
        int     cur_row = 0;
        int     cur_step = 0;

        block_xfer_sequencer u_block_xfer_sequencer
        (
                .i_clk                  (i_clk),
                .i_reset                (i_reset),
                .i_instruction          (i_instruction),
                .i_instruction_valid    (i_instruction_valid),
                .i_hold                 (i_hold),
                .i_clear                (i_clear),
                .o_uop                  (o_uop),
                .o_uop_valid            (o_uop_valid),
                .o_rd_ext               (o_rd_ext),
                .o_rn_ext               (o_rn_ext),
                .o_rm_ext               (o_rm_ext),
                .o_stall                (o_stall)
        );

        always #5 i_clk = ~i_clk;

        always @(posedge i_clk)
        begin
                cycle_count = cycle_count + 1;
                if (cycle_count >= cycle_limit)
                begin
                        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
                        $display("TB FAILED");
                        $fatal(1, "simulation timed out");
                end
        end

        function automatic logic [31:0] dp_uop(logic [3:0] cond, logic imm, logic [3:0] opc,
                                               logic s, logic [3:0] rn, logic [3:0] rd,
                                               logic [11:0] op2);
                return {cond, 2'b00, imm, opc, s, rn, rd, op2};
        endfunction

        // Single transfer with an added immediate offset.
        function automatic logic [31:0] ldst_uop(logic [3:0] cond, logic p, logic b, logic wb,
                                                 logic l, logic [3:0] rn, logic [3:0] rd,
                                                 logic [11:0] offset);
                return {cond, 2'b01, 1'b0, p, 1'b1, b, wb, l, rn, rd, offset};
        endfunction

        // List of exactly bits registers that never holds the PC.
        function automatic logic [15:0] random_list(int bits);
                logic [15:0] list;
                logic [3:0]  pick;
                list = '0;
                while ($countones(list) < bits)
                begin
                        pick       = 4'($unsigned($random(seed)) % 15);
                        list[pick] = 1'b1;
                end
                return list;
        endfunction

        task automatic set_row(input int r, input seq_pkg::instr_t instr, input logic [7:0] hold,
                               input int clear_at, input int count);
                row_instr[r]    = instr;
                row_hold[r]     = hold;
                row_clear_at[r] = clear_at;
                row_count[r]    = count;
        endtask

        task automatic add_expected(input seq_pkg::instr_t uop, input logic [2:0] ext);
                exp_uop.push_back(uop);
                exp_ext.push_back(ext);
        endtask

        task automatic build_expected(input seq_pkg::instr_t instr);
                logic [31:0] w;
                logic [3:0]  cond;
                logic [3:0]  rn;
                logic [7:0]  size;
                logic        up;
                logic        p_eff;
                logic        pc_load;
                w       = instr;
                cond    = w[31:28];
                rn      = w[19:16];
                up      = w[23];
                size    = 8'($countones(w[15:0]) * 4);
                p_eff   = up ? w[24] : !w[24];
                pc_load = w[20] && w[15];
                exp_uop.delete();
                exp_ext.delete();
                if (w[27:25] == 3'b100)
                begin
                        // Base copy into D0.
                        if (up)
                                add_expected(dp_uop(cond, 1'b0, seq_pkg::OPC_MOV, 1'b0, 4'd0,
                                                    seq_pkg::HID_D0, {8'd0, rn}), 3'b100);
                        else
                                add_expected(dp_uop(cond, 1'b1, seq_pkg::OPC_SUB, 1'b0, rn,
                                                    seq_pkg::HID_D0, {4'd0, size}), 3'b100);
                        for (int r = 0; r < 16; r++)
                        begin
                                if (w[r])
                                        add_expected(ldst_uop(cond, p_eff, 1'b0, p_eff, w[20],
                                                              seq_pkg::HID_D0,
                                                              (pc_load && r == 15) ?
                                                              seq_pkg::HID_D1 : 4'(r), 12'd4),
                                                     {pc_load && r == 15, 2'b10});
                        end
                        if (!w[21])
                                add_expected('0, 3'b000);
                        else if (up)
                                add_expected(dp_uop(cond, 1'b0, seq_pkg::OPC_MOV, 1'b0, 4'd0, rn,
                                                    {8'd0, seq_pkg::HID_D0}), 3'b001);
                        else
                                add_expected(dp_uop(cond, 1'b1, seq_pkg::OPC_SUB, 1'b0, rn, rn,
                                                    {4'd0, size}), 3'b000);
                        if (pc_load)
                                add_expected(dp_uop(cond, 1'b0, seq_pkg::OPC_MOV, w[22], 4'd0,
                                                    4'd15, {8'd0, seq_pkg::HID_D1}), 3'b001);
                end
                else if ({w[27:23], w[21:20], w[11:4]} == {5'b00010, 2'b00, 8'b0000_1001})
                begin
                        add_expected(ldst_uop(cond, 1'b1, w[22], 1'b0, 1'b1, rn,
                                              seq_pkg::HID_D0, 12'd0), 3'b100);
                        add_expected(ldst_uop(cond, 1'b1, w[22], 1'b0, 1'b0, rn, w[3:0], 12'd0),
                                     3'b000);
                        add_expected(dp_uop(cond, 1'b0, seq_pkg::OPC_MOV, 1'b0, 4'd0, w[15:12],
                                            {8'd0, seq_pkg::HID_D0}), 3'b001);
                end
                else
                        add_expected(instr, 3'b000);
        endtask

        task automatic compare_uop(input seq_pkg::instr_t got, input logic got_valid,
                                   input seq_pkg::instr_t exp);
                if (got_valid !== 1'b1)
                begin
                        $display("[FAIL] time %0t row %0d step %0d: o_uop_valid got %b expected 1",
                                 $time, cur_row, cur_step, got_valid);
                        $display("TB FAILED");
                        $fatal(1, "micro-op valid mismatch");
                end
                else if (got !== exp)
                begin
                        $display("[FAIL] time %0t row %0d step %0d: o_uop got %h expected %h",
                                 $time, cur_row, cur_step, got, exp);
                        $display("TB FAILED");
                        $fatal(1, "micro-op mismatch");
                end
        endtask

        task automatic compare_ext(input logic [2:0] got, input logic [2:0] exp);
                if (got !== exp)
                begin
                        $display("[FAIL] time %0t row %0d step %0d: %s got %b expected %b",
                                 $time, cur_row, cur_step, "{o_rd_ext,o_rn_ext,o_rm_ext}",
                                 got, exp);
                        $display("TB FAILED");
                        $fatal(1, "extension bit mismatch");
                end
        endtask

        task automatic compare_stall(input logic got, input logic exp);
                if (got !== exp)
                begin
                        $display("[FAIL] time %0t row %0d step %0d: o_stall got %b expected %b",
                                 $time, cur_row, cur_step, got, exp);
                        $display("TB FAILED");
                        $fatal(1, "stall mismatch");
                end
        endtask

        // Drive one cycle at the rising edge and check it at the falling edge.
        task automatic run_cycle(input seq_pkg::instr_t instr, input logic hold,
                                 input logic clear, input int step);
                @(posedge i_clk);
                i_instruction       <= instr;
                i_instruction_valid <= 1'b1;
                i_hold              <= hold;
                i_clear             <= clear;
                @(negedge i_clk);
                cur_step = step;
                compare_uop(o_uop, o_uop_valid, exp_uop[step]);
                compare_ext({o_rd_ext, o_rn_ext, o_rm_ext}, exp_ext[step]);
                compare_stall(o_stall, step != exp_uop.size() - 1);
        endtask

        initial
        begin
                int   step;
                logic done;
                logic clear_now;
                i_reset             = 1'b1;
                i_instruction       = '0;
                i_instruction_valid = 1'b0;
                i_hold              = 1'b0;
                i_clear             = 1'b0;

                set_row(0, 32'hE282_1005, 8'h00, -1, 1);
                set_row(1, 32'hE8B3_0000 | {16'd0, random_list(5)}, 8'h00, -1, 7);
                set_row(2, 32'hE9A4_0000 | {16'd0, random_list(4)}, 8'h05, -1, 6);
                set_row(3, 32'hE915_0085, 8'h00, -1, 5);
                set_row(4, 32'hE806_0000, 8'h00, -1, 2);
                set_row(5, 32'h08F1_8204, 8'h00, -1, 6);
                set_row(6, 32'hE102_0091, 8'h00, -1, 3);
                set_row(7, 32'hE145_3094, 8'h02, -1, 3);
                set_row(8, 32'hE8A7_0000 | {16'd0, random_list(6)}, 8'h00, 3, 8);
                set_row(9, 32'hE1A0_0001, 8'h00, -1, 1);

                cycle_limit = 50;
                for (int r = 0; r < NUM_ROWS; r++)
                        cycle_limit = cycle_limit + row_count[r] + $countones(row_hold[r]);

                repeat (3) @(posedge i_clk);
                i_reset <= 1'b0;

                for (int r = 0; r < NUM_ROWS; r++)
                begin
                        cur_row = r;
                        build_expected(row_instr[r]);
                        if (exp_uop.size() != row_count[r])
                        begin
                                $display("Row %0d: model gives %0d micro-ops, table gives %0d",
                                         r, exp_uop.size(), row_count[r]);
                                $display("TB FAILED");
                                $fatal(1, "table and reference model disagree");
                        end
                        step = 0;
                        done = 1'b0;
                        // Fetch keeps the instruction while o_stall is high.
                        while (!done)
                        begin
                                clear_now = (step == row_clear_at[r]);
                                if (step < 8 && row_hold[r][3'(step)])
                                        run_cycle(row_instr[r], 1'b1, 1'b0, step);
                                run_cycle(row_instr[r], 1'b0, clear_now, step);
                                done = !o_stall || clear_now;
                                step++;
                        end
                end

                @(posedge i_clk);
                i_instruction_valid <= 1'b0;
                i_clear             <= 1'b0;
                @(negedge i_clk);
                $display("TB PASSED");
                $finish;
        end

endmodule

/* tb.f */
design/seq_pkg.sv
design/reglist_walker.sv
design/seq_fsm.sv
design/uop_builder.sv
design/block_xfer_sequencer.sv
verification/seq_assertions.sv
verification/tb_block_xfer_sequencer.sv

/* Makefile */
TOP := tb_block_xfer_sequencer

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -o $(TOP)
	@out=$$(./obj_dir/$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir
